// File: hdl/unpack_config.svh
`ifndef UNPACK_CONFIG_SVH
`define UNPACK_CONFIG_SVH

// input word width, also the widest field
`define UNPACK_WORD_W 32

// holds any count from 0 up to two words
`define UNPACK_CNT_W ($clog2(2*`UNPACK_WORD_W)+1)

// input words buffered ahead of the unpacker
`define UNPACK_FIFO_DEPTH 4

`endif

// File: hdl/unpack_pkg.sv
`include "unpack_config.svh"

package unpack_pkg;

   // one input word
   typedef logic [`UNPACK_WORD_W-1:0] word_t;

   // one output field, right aligned
   typedef logic [`UNPACK_WORD_W-1:0] field_t;

   // requested field width
   typedef logic [`UNPACK_CNT_W-1:0] width_t;

   // residual bits in the shift register
   typedef logic [`UNPACK_CNT_W-1:0] count_t;

   // unpacker control states
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SHIFT,
      ST_REFILL
   } unpack_state_e;

endpackage

// File: hdl/word_fifo.sv
`timescale 1ns/1ns
`include "unpack_config.svh"

module word_fifo
   import unpack_pkg::*;
#(
   parameter int DEPTH = `UNPACK_FIFO_DEPTH
) (
   input  logic  clk_i,
   input  logic  rst_n_i,
   input  logic  clear_i,

   input  word_t wr_data_i,
   input  logic  wr_valid_i,
   output logic  wr_ready_o,

   output word_t rd_data_o,
   output logic  rd_valid_o,
   input  logic  rd_ready_i
);

   // pointers wrap naturally on a power of two depth
   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam logic [AW:0] FULL_CNT = (AW+1)'(DEPTH);

   word_t         mem_q [DEPTH];
   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [AW:0]   cnt_q;
   logic          push;
   logic          pop;

   assign wr_ready_o = (cnt_q != FULL_CNT);
   assign rd_valid_o = (cnt_q != '0);
   assign rd_data_o  = mem_q[rd_ptr_q];

   assign push = wr_valid_i && wr_ready_o;
   assign pop  = rd_valid_o && rd_ready_i;

   // storage
   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_q[wr_ptr_q] <= wr_data_i;
      end
   end

   // pointers and occupancy
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else if (clear_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   cnt_q <= cnt_q + 1'b1;
            2'b01:   cnt_q <= cnt_q - 1'b1;
            default: cnt_q <= cnt_q;
         endcase
      end
   end

   // a refused write neither moves the write pointer nor adds to the count
   a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
      wr_valid_i && !wr_ready_o |=> $stable(wr_ptr_q) && (cnt_q <= $past(cnt_q)));

   // no read advance from an empty buffer
   a_no_read_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
      rd_ready_i && !rd_valid_o |=> $stable(rd_ptr_q));

   // pointer distance agrees with the occupancy count
   a_occupancy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (cnt_q <= FULL_CNT) && ((wr_ptr_q - rd_ptr_q) == cnt_q[AW-1:0]));

endmodule

// File: hdl/bit_acc.sv
`timescale 1ns/1ns
`include "unpack_config.svh"

module bit_acc
   import unpack_pkg::*;
(
   input  logic   clk_i,
   input  logic   rst_n_i,
   input  logic   clear_i,
   input  logic   load_i,
   input  logic   emit_i,
   input  width_t width_i,
   output count_t count_o
);

   localparam count_t WORD_BITS = count_t'(`UNPACK_WORD_W);
   localparam count_t MAX_BITS  = count_t'(2*`UNPACK_WORD_W);

   count_t count_q;
   count_t add_bits;
   count_t sub_bits;

   // load and emit may both apply in one cycle
   assign add_bits = load_i ? WORD_BITS : '0;
   assign sub_bits = emit_i ? count_t'(width_i) : '0;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         count_q <= '0;
      end else if (clear_i) begin
         count_q <= '0;
      end else begin
         count_q <= count_q + add_bits - sub_bits;
      end
   end

   assign count_o = count_q;

   // shift register is two words deep
   a_count_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      count_q <= MAX_BITS);

   // an emitted field must be backed by held or arriving bits
   a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
      emit_i |-> (count_q + add_bits) >= count_t'(width_i));

endmodule

// File: hdl/field_unpack.sv
`timescale 1ns/1ns
`include "unpack_config.svh"

module field_unpack
   import unpack_pkg::*;
(
   input  logic   clk_i,
   input  logic   rst_n_i,
   input  logic   clear_i,

   // words from the fifo
   input  word_t  word_i,
   input  logic   word_valid_i,
   output logic   word_ready_o,

   // field output
   input  width_t width_i,
   output field_t field_o,
   output logic   field_valid_o,
   input  logic   field_ready_i,

   // residual bookkeeping
   input  count_t count_i,
   output logic   load_o,
   output logic   emit_o
);

   localparam int     WW     = `UNPACK_WORD_W;
   localparam count_t FULL_W = count_t'(2*WW);

   unpack_state_e   state_q;
   unpack_state_e   state_d;
   logic [2*WW-1:0] sr_q;
   logic [2*WW-1:0] sr_d;
   logic [2*WW-1:0] keep_mask;
   logic [2*WW-1:0] word_placed;
   logic [2*WW-1:0] field_wide;
   logic            short;

   // not enough residual bits for the requested field
   assign short = (count_i < width_i);

   always_comb begin
      state_d       = state_q;
      word_ready_o  = 1'b0;
      field_valid_o = 1'b0;
      case (state_q)
         ST_IDLE: begin
            // nothing held yet
            word_ready_o = 1'b1;
            if (word_valid_i) begin
               state_d = ST_SHIFT;
            end
         end
         ST_SHIFT: begin
            if (!short) begin
               field_valid_o = 1'b1;
            end else begin
               // top up in the same cycle when a word is waiting
               word_ready_o = 1'b1;
               if (!word_valid_i) begin
                  state_d = ST_REFILL;
               end
            end
         end
         ST_REFILL: begin
            if (!short) begin
               // width dropped while starved
               field_valid_o = 1'b1;
               state_d       = ST_SHIFT;
            end else begin
               word_ready_o = 1'b1;
               if (word_valid_i) begin
                  state_d = ST_SHIFT;
               end
            end
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   assign load_o = word_valid_i && word_ready_o;
   assign emit_o = field_valid_o && field_ready_i;

   // bits below the residual are dropped before a new word goes in
   assign keep_mask   = ~({(2*WW){1'b1}} >> count_i);
   assign word_placed = {word_i, {WW{1'b0}}} >> count_i;

   // top width_i bits brought down to the lsb
   assign field_wide = sr_q >> (FULL_W - count_t'(width_i));
   assign field_o    = field_wide[WW-1:0];

   always_comb begin
      sr_d = sr_q;
      if (load_o) begin
         sr_d = (sr_q & keep_mask) | word_placed;
      end else if (emit_o) begin
         sr_d = sr_q << width_i;
      end
   end

   // shift register with the oldest bit at the msb
   always_ff @(posedge clk_i) begin
      sr_q <= sr_d;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
      end else if (clear_i) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // width request must be legal whenever a field is offered
   a_width_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      field_valid_o |-> (width_i >= width_t'(1)) && (width_i <= width_t'(WW)));

   // stalled field stays put until taken
   a_field_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
      field_valid_o && !field_ready_i |=> field_valid_o && $stable(field_o));

endmodule

// File: hdl/unpack_top.sv
`timescale 1ns/1ns

module unpack_top
   import unpack_pkg::*;
(
   input  logic   clk_i,
   input  logic   rst_n_i,
   input  logic   clear_i,

   input  word_t  word_i,
   input  logic   word_valid_i,
   output logic   word_ready_o,

   input  width_t field_width_i,
   output field_t field_o,
   output logic   field_valid_o,
   input  logic   field_ready_i
);

   word_t  fifo_word;
   logic   fifo_valid;
   logic   fifo_ready;
   logic   load;
   logic   emit;
   count_t count;

   // input decoupling
   word_fifo u_fifo (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .clear_i    (clear_i),
      .wr_data_i  (word_i),
      .wr_valid_i (word_valid_i),
      .wr_ready_o (word_ready_o),
      .rd_data_o  (fifo_word),
      .rd_valid_o (fifo_valid),
      .rd_ready_i (fifo_ready)
   );

   field_unpack u_unpack (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .clear_i       (clear_i),
      .word_i        (fifo_word),
      .word_valid_i  (fifo_valid),
      .word_ready_o  (fifo_ready),
      .width_i       (field_width_i),
      .field_o       (field_o),
      .field_valid_o (field_valid_o),
      .field_ready_i (field_ready_i),
      .count_i       (count),
      .load_o        (load),
      .emit_o        (emit)
   );

   // residual bit count seen by the unpacker
   bit_acc u_acc (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .clear_i (clear_i),
      .load_i  (load),
      .emit_i  (emit),
      .width_i (field_width_i),
      .count_o (count)
   );

endmodule

// File: testbench/tb_unpack_checks.svh
`ifndef TB_UNPACK_CHECKS_SVH
`define TB_UNPACK_CHECKS_SVH

// running totals over every compare
int checks_passed = 0;
int checks_failed = 0;

// one unpacked field against the bitstream model
task automatic check_field(input string test, input string what,
                           input field_t expected, input field_t actual);
   if (actual === expected) begin
      checks_passed++;
   end else begin
      checks_failed++;
      $display("CHECK FAILED %s %s expected 0x%08h actual 0x%08h at %0t ns",
               test, what, expected, actual, $time);
   end
endtask

// single handshake or status bit
task automatic check_flag(input string test, input string what,
                          input logic expected, input logic actual);
   if (actual === expected) begin
      checks_passed++;
   end else begin
      checks_failed++;
      $display("CHECK FAILED %s %s expected %b actual %b at %0t ns",
               test, what, expected, actual, $time);
   end
endtask

// one line per finished test
task automatic report_test(input string test, input int fails_before);
   int fails;
   fails = checks_failed - fails_before;
   if (fails == 0) begin
      $display("test %s: ok", test);
   end else begin
      $display("test %s: %0d check(s) wrong", test, fails);
   end
endtask

task automatic report_counts();
   $display("summary: %0d checks passed, %0d checks failed",
            checks_passed, checks_failed);
endtask

`endif

// File: testbench/tb_unpack.sv
`timescale 1ns/1ns
`include "unpack_config.svh"

module tb_unpack
   import unpack_pkg::*;
();

   localparam int PERIOD    = 100;
   localparam int NUM_TESTS = 5;

   logic   clk_i = 1'b0;
   logic   rst_n_i;
   logic   clear_i;
   word_t  word_i;
   logic   word_valid_i;
   logic   word_ready_o;
   width_t field_width_i;
   field_t field_o;
   logic   field_valid_o;
   logic   field_ready_i;

   // stimulus table, widths and values are lists of eight used in turn
   string        tbl_name   [NUM_TESTS];
   int           tbl_count  [NUM_TESTS];
   logic [63:0]  tbl_widths [NUM_TESTS];
   logic [255:0] tbl_values [NUM_TESTS];
   bit           tbl_rand   [NUM_TESTS];
   bit           tbl_bp     [NUM_TESTS];
   int           tbl_clear  [NUM_TESTS];

   field_t exp_q  [$];
   width_t wid_q  [$];
   word_t  word_q [$];
   int     seed;
   bit     stop_drive;

   `include "tb_unpack_checks.svh"

   unpack_top u_dut (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .clear_i       (clear_i),
      .word_i        (word_i),
      .word_valid_i  (word_valid_i),
      .word_ready_o  (word_ready_o),
      .field_width_i (field_width_i),
      .field_o       (field_o),
      .field_valid_o (field_valid_o),
      .field_ready_i (field_ready_i)
   );

   always #(PERIOD/2) clk_i = ~clk_i;

   task automatic add_row(input int t, input string name, input int count,
                          input logic [63:0] widths, input logic [255:0] values,
                          input bit rnd, input bit bp, input int clr);
      tbl_name[t]   = name;
      tbl_count[t]  = count;
      tbl_widths[t] = widths;
      tbl_values[t] = values;
      tbl_rand[t]   = rnd;
      tbl_bp[t]     = bp;
      tbl_clear[t]  = clr;
   endtask

   task automatic build_table();
      add_row(0, "fixed_8bit", 16, 64'h08080808_08080808,
              {32'h000000a5, 32'h0000003c, 32'h000000f0, 32'h0000000f,
               32'h00000081, 32'h0000007e, 32'h00000155, 32'h000000c3}, 0, 0, -1);
      add_row(1, "full_word", 8, 64'h20202020_20202020,
              {32'h80000001, 32'hdeadbeef, 32'h12345678, 32'hffffffff,
               32'h00000000, 32'h5a5a5a5a, 32'h0f0f0f0f, 32'hc0ffee11}, 0, 0, -1);
      // 3, 13, 29, 1, 31, 2, 32, 11 with oversized values
      add_row(2, "mixed_cross", 24, 64'h030d1d01_1f02200b,
              {32'hffffffff, 32'h00001abc, 32'h1eadbeef, 32'h00000001,
               32'h7654321f, 32'h00000002, 32'ha5a5a5a5, 32'h000007ff}, 0, 0, -1);
      add_row(3, "random_backpressure", 60, '0, '0, 1, 1, -1);
      add_row(4, "clear_mid_stream", 12, 64'h050b0709_0e111503,
              {32'h00000013, 32'h000005a5, 32'h0000006b, 32'h00000155,
               32'h00002c3d, 32'h0001f00f, 32'h00123456, 32'h00000005}, 0, 0, 5);
   endtask

   // msb first bitstream model, inverted values give a different stream
   task automatic build_stream(input int t, input bit inv);
      int     k;
      int     b;
      int     w;
      field_t v;
      word_t  wd;
      bit     bits [$];
      exp_q.delete();
      wid_q.delete();
      word_q.delete();
      for (k = 0; k < tbl_count[t]; k++) begin
         if (tbl_rand[t]) begin
            w = ($random(seed) & 31) + 1;
            v = $random(seed);
         end else begin
            w = int'(tbl_widths[t][63-8*(k%8) -: 8]);
            v = tbl_values[t][255-32*(k%8) -: 32];
         end
         if (inv) begin
            v = ~v;
         end
         v = v & (field_t'('1) >> (`UNPACK_WORD_W - w));
         wid_q.push_back(width_t'(w));
         exp_q.push_back(v);
         for (b = w - 1; b >= 0; b--) begin
            bits.push_back(v[b]);
         end
      end
      // zero pad up to a whole word
      while (bits.size() % `UNPACK_WORD_W != 0) begin
         bits.push_back(1'b0);
      end
      for (k = 0; k < bits.size(); k++) begin
         wd = {wd[`UNPACK_WORD_W-2:0], bits[k]};
         if (k % `UNPACK_WORD_W == `UNPACK_WORD_W - 1) begin
            word_q.push_back(wd);
         end
      end
   endtask

   task automatic drive_words();
      int i;
      i = 0;
      @(negedge clk_i);
      while (i < word_q.size() && !stop_drive) begin
         word_i       = word_q[i];
         word_valid_i = 1'b1;
         #(PERIOD/4);
         if (word_ready_o) begin
            i++;
         end
         @(negedge clk_i);
      end
      word_valid_i = 1'b0;
   endtask

   task automatic collect_fields(input int t, input int n);
      int     got;
      bit     held;
      field_t held_val;
      got  = 0;
      held = 1'b0;
      while (got < n) begin
         @(negedge clk_i);
         field_width_i = wid_q[got];
         field_ready_i = tbl_bp[t] ? (($random(seed) & 3) != 0) : 1'b1;
         #(PERIOD/4);
         // stalled field must not move
         if (held) begin
            check_flag(tbl_name[t], "held field_valid_o", 1'b1, field_valid_o);
            check_field(tbl_name[t], "held field_o", held_val, field_o);
         end
         held     = field_valid_o && !field_ready_i;
         held_val = field_o;
         if (field_valid_o && field_ready_i) begin
            check_field(tbl_name[t], "field_o", exp_q[got], field_o);
            got++;
         end
      end
      stop_drive = 1'b1;
      @(negedge clk_i);
      field_ready_i = 1'b0;
   endtask

   task automatic run_stream(input int t, input int n);
      stop_drive = 1'b0;
      fork
         drive_words();
         collect_fields(t, n);
      join
   endtask

   task automatic pulse_clear(input string test);
      @(negedge clk_i);
      clear_i = 1'b1;
      @(negedge clk_i);
      clear_i = 1'b0;
      #(PERIOD/4);
      check_flag(test, "field_valid_o after clear", 1'b0, field_valid_o);
      check_flag(test, "word_ready_o after clear", 1'b1, word_ready_o);
   endtask

   task automatic run_test(input int t);
      pulse_clear(tbl_name[t]);
      if (tbl_clear[t] >= 0) begin
         build_stream(t, 1'b1);
         run_stream(t, tbl_clear[t]);
         // drop the partly consumed stream
         pulse_clear(tbl_name[t]);
      end
      build_stream(t, 1'b0);
      run_stream(t, tbl_count[t]);
   endtask

   initial begin
      int t;
      int fails_before;
      seed          = 72908;
      rst_n_i       = 1'b0;
      clear_i       = 1'b0;
      word_i        = '0;
      word_valid_i  = 1'b0;
      field_width_i = width_t'(8);
      field_ready_i = 1'b0;
      stop_drive    = 1'b0;
      build_table();
      repeat (16) @(negedge clk_i);
      rst_n_i = 1'b1;
      @(negedge clk_i);
      #(PERIOD/4);
      fails_before = checks_failed;
      check_flag("after_reset", "field_valid_o", 1'b0, field_valid_o);
      check_flag("after_reset", "word_ready_o", 1'b1, word_ready_o);
      report_test("after_reset", fails_before);
      for (t = 0; t < NUM_TESTS; t++) begin
         fails_before = checks_failed;
         run_test(t);
         report_test(tbl_name[t], fails_before);
      end
      report_counts();
      if (checks_failed == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // each field fills at most one word
   initial begin
      int words;
      int t;
      #1;
      words = 0;
      for (t = 0; t < NUM_TESTS; t++) begin
         words += (tbl_clear[t] >= 0) ? 2*tbl_count[t] : tbl_count[t];
      end
      repeat (200*words + 1000) @(posedge clk_i);
      $display("watchdog: run timed out after %0d cycles", 200*words + 1000);
      $display("Verification failed");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+hdl
+incdir+testbench
hdl/unpack_pkg.sv
hdl/word_fifo.sv
hdl/bit_acc.sv
hdl/field_unpack.sv
hdl/unpack_top.sv
testbench/tb_unpack.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_unpack
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
